// File: hw/cacheGeomPkg.sv
`default_nettype none

package cacheGeomPkg;

  // address and data widths
  localparam int AddrW = 32;
  localparam int Xlen = 64;

  // address split: tag | index | offset
  localparam int OffsetW = 5;
  localparam int IndexW = 6;
  localparam int TagW = AddrW - IndexW - OffsetW;

  // geometry of one way
  localparam int NumSets = 1 << IndexW;
  localparam int LineW = 8 << OffsetW;

  typedef logic [AddrW-1:0] addrT;
  typedef logic [Xlen-1:0] wordT;
  typedef logic [TagW-1:0] tagT;
  typedef logic [IndexW-1:0] indexT;
  typedef logic [LineW-1:0] lineT;

  // word within a line, taken from offset bits above the byte lane
  typedef logic [1:0] wordSelT;

  // lookup and refill sequence of the controller
  typedef enum logic [2:0] {
    Idle,
    Compare,
    Miss,
    Refill,
    Fill
  } cacheStateT;

endpackage

`default_nettype wire

// File: hw/refillBusPkg.sv
`default_nettype none

package refillBusPkg;

  // refill burst, one word per beat in address order
  localparam int BeatsPerLine = 4;
  typedef logic [$clog2(BeatsPerLine)-1:0] beatCntT;

  // configuration register port
  localparam int CfgAddrW = 2;
  localparam int CfgDataW = 32;
  typedef logic [CfgAddrW-1:0] cfgAddrT;
  typedef logic [CfgDataW-1:0] cfgDataT;

  // bit 0 enable, bit 1 flush (write one, reads as zero)
  localparam cfgAddrT CfgCtrlAddr = 2'd0;
  // write of any value clears the counter
  localparam cfgAddrT CfgHitAddr = 2'd1;
  localparam cfgAddrT CfgMissAddr = 2'd2;

endpackage

`default_nettype wire

// File: hw/cacheDataArray.sv
`default_nettype none

module cacheDataArray (
  input  logic               clk,
  input  logic               en_i,
  input  logic               we_i,
  input  cacheGeomPkg::indexT index_i,
  input  cacheGeomPkg::lineT  wrLine_i,
  output cacheGeomPkg::lineT  rdLine_o
);

  // one full line per set, single port
  cacheGeomPkg::lineT lineMem [cacheGeomPkg::NumSets];

  // read data stays on the output until the next enabled read
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        lineMem[index_i] <= wrLine_i;
      end else begin
        rdLine_o <= lineMem[index_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cacheTagStore.sv
`default_nettype none

module cacheTagStore (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               lookupEn_i,
  input  cacheGeomPkg::indexT lookupIndex_i,
  input  cacheGeomPkg::tagT   lookupTag_i,
  input  logic               fillEn_i,
  input  logic               touchEn_i,
  input  logic               touchWay_i,
  input  logic               flush_i,
  output logic               hitWay0_o,
  output logic               hitWay1_o,
  output logic               victimWay_o
);

  cacheGeomPkg::tagT tagArr0 [cacheGeomPkg::NumSets];
  cacheGeomPkg::tagT tagArr1 [cacheGeomPkg::NumSets];

  logic [cacheGeomPkg::NumSets-1:0] valid0;
  logic [cacheGeomPkg::NumSets-1:0] valid1;
  // lru bit names the way to replace next
  logic [cacheGeomPkg::NumSets-1:0] lru;

  cacheGeomPkg::tagT   tagQ0;
  cacheGeomPkg::tagT   tagQ1;
  logic                validQ0;
  logic                validQ1;
  cacheGeomPkg::indexT indexQ;

  // snapshot of the set taken when a request is accepted
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagQ0 <= tagArr0[lookupIndex_i];
      tagQ1 <= tagArr1[lookupIndex_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ0 <= 1'b0;
      validQ1 <= 1'b0;
      indexQ <= '0;
    end else if (lookupEn_i) begin
      validQ0 <= valid0[lookupIndex_i];
      validQ1 <= valid1[lookupIndex_i];
      indexQ <= lookupIndex_i;
    end
  end

  assign hitWay0_o = validQ0 && (tagQ0 == lookupTag_i);
  assign hitWay1_o = validQ1 && (tagQ1 == lookupTag_i);
  assign victimWay_o = lru[indexQ];

  // tag write into the victim way of the looked-up set
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      if (victimWay_o) begin
        tagArr1[indexQ] <= lookupTag_i;
      end else begin
        tagArr0[indexQ] <= lookupTag_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0 <= '0;
      valid1 <= '0;
      lru <= '0;
    end else if (flush_i) begin
      valid0 <= '0;
      valid1 <= '0;
      lru <= '0;
    end else if (fillEn_i) begin
      if (victimWay_o) begin
        valid1[indexQ] <= 1'b1;
      end else begin
        valid0[indexQ] <= 1'b1;
      end
      lru[indexQ] <= ~victimWay_o;
    end else if (touchEn_i) begin
      // other way becomes the older one
      lru[indexQ] <= ~touchWay_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/cacheCtrl.sv
`default_nettype none

module cacheCtrl (
  input  logic               clk,
  input  logic               rst_n,
  // pipeline
  input  logic               valid_i,
  input  cacheGeomPkg::addrT  addr_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output cacheGeomPkg::wordT  rdData_o,
  // refill
  output logic               memRdValid_o,
  output cacheGeomPkg::addrT  memAddr_o,
  input  logic               memRdBeat_i,
  input  logic               memRdLast_i,
  input  cacheGeomPkg::wordT  memRdData_i,
  // configuration
  input  logic               cacheEnable_i,
  // tag store
  input  logic               hitWay0_i,
  input  logic               hitWay1_i,
  input  logic               victimWay_i,
  output logic               lookupEn_o,
  output cacheGeomPkg::indexT lookupIndex_o,
  output cacheGeomPkg::tagT   lookupTag_o,
  output logic               fillEn_o,
  output logic               touchEn_o,
  output logic               touchWay_o,
  // data arrays
  output logic               dataEn_o,
  output logic               dataWe0_o,
  output logic               dataWe1_o,
  output cacheGeomPkg::indexT dataIndex_o,
  output cacheGeomPkg::lineT  fillLine_o,
  input  cacheGeomPkg::lineT  way0Line_i,
  input  cacheGeomPkg::lineT  way1Line_i,
  // event counters
  output logic               hitPulse_o,
  output logic               missPulse_o
);

  localparam int OffW = cacheGeomPkg::OffsetW;
  localparam int Xlen = cacheGeomPkg::Xlen;

  cacheGeomPkg::cacheStateT state;
  cacheGeomPkg::cacheStateT nextState;

  cacheGeomPkg::addrT      reqAddr;
  cacheGeomPkg::indexT     reqIndex;
  cacheGeomPkg::wordSelT   reqWordSel;
  cacheGeomPkg::lineT      fillLine;
  cacheGeomPkg::lineT      hitLine;
  refillBusPkg::beatCntT   beatCnt;

  logic inCompare;
  logic inFill;
  logic inBurst;
  logic hit;
  logic accept;
  logic wayWe;

  function automatic cacheGeomPkg::wordT pickWord(cacheGeomPkg::lineT line,
                                                  cacheGeomPkg::wordSelT sel);
    return line[sel*Xlen +: Xlen];
  endfunction

  assign inCompare = (state == cacheGeomPkg::Compare);
  assign inFill = (state == cacheGeomPkg::Fill);
  assign inBurst = (state == cacheGeomPkg::Miss) || (state == cacheGeomPkg::Refill);

  // tag store may match while disabled, ignore it then
  assign hit = inCompare && cacheEnable_i && (hitWay0_i || hitWay1_i);

  assign addrOk_o = (state == cacheGeomPkg::Idle) || hit;
  assign accept = valid_i && addrOk_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cacheGeomPkg::Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cacheGeomPkg::Idle: begin
        if (valid_i) begin
          nextState = cacheGeomPkg::Compare;
        end
      end
      cacheGeomPkg::Compare: begin
        if (!hit) begin
          nextState = cacheGeomPkg::Miss;
        end else if (!valid_i) begin
          nextState = cacheGeomPkg::Idle;
        end
      end
      // the first beat may already come back in Miss
      cacheGeomPkg::Miss, cacheGeomPkg::Refill: begin
        if (memRdBeat_i && memRdLast_i) begin
          nextState = cacheGeomPkg::Fill;
        end else begin
          nextState = cacheGeomPkg::Refill;
        end
      end
      cacheGeomPkg::Fill: nextState = cacheGeomPkg::Idle;
      default: nextState = cacheGeomPkg::Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqAddr <= '0;
    end else if (accept) begin
      reqAddr <= addr_i;
    end
  end

  assign reqIndex = reqAddr[OffW +: cacheGeomPkg::IndexW];
  assign reqWordSel = reqAddr[OffW-1 -: 2];

  // beats land at their word slot in address order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (inCompare) begin
      beatCnt <= '0;
    end else if (inBurst && memRdBeat_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (inBurst && memRdBeat_i) begin
      fillLine[beatCnt*Xlen +: Xlen] <= memRdData_i;
    end
  end

  assign memRdValid_o = inBurst;
  assign memAddr_o = {reqAddr[cacheGeomPkg::AddrW-1:OffW], {OffW{1'b0}}};

  // lookup reads the incoming set, later steps use the latched request
  assign lookupEn_o = accept;
  assign lookupIndex_o = addr_i[OffW +: cacheGeomPkg::IndexW];
  assign lookupTag_o = reqAddr[cacheGeomPkg::AddrW-1 -: cacheGeomPkg::TagW];

  assign wayWe = inFill && cacheEnable_i;
  assign fillEn_o = wayWe;
  assign touchEn_o = hit;
  assign touchWay_o = hitWay1_i;

  assign dataEn_o = accept || wayWe;
  assign dataWe0_o = wayWe && !victimWay_i;
  assign dataWe1_o = wayWe && victimWay_i;
  assign dataIndex_o = accept ? lookupIndex_o : reqIndex;
  assign fillLine_o = fillLine;

  assign hitLine = hitWay1_i ? way1Line_i : way0Line_i;

  // word goes out on a hit in Compare or forwarded at Fill
  assign dataOk_o = hit || inFill;
  assign rdData_o = inFill ? pickWord(fillLine, reqWordSel) : pickWord(hitLine, reqWordSel);

  assign hitPulse_o = hit;
  assign missPulse_o = inCompare && !hit;

endmodule

`default_nettype wire

// File: hw/cacheCfgRegs.sv
`default_nettype none

module cacheCfgRegs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cfgWe_i,
  input  refillBusPkg::cfgAddrT cfgAddr_i,
  input  refillBusPkg::cfgDataT cfgWdata_i,
  output refillBusPkg::cfgDataT cfgRdata_o,
  input  logic                  hitPulse_i,
  input  logic                  missPulse_i,
  output logic                  cacheEnable_o,
  output logic                  flushPulse_o
);

  refillBusPkg::cfgDataT hitCnt;
  refillBusPkg::cfgDataT missCnt;

  logic ctrlWr;
  logic hitWr;
  logic missWr;

  assign ctrlWr = cfgWe_i && (cfgAddr_i == refillBusPkg::CfgCtrlAddr);
  assign hitWr = cfgWe_i && (cfgAddr_i == refillBusPkg::CfgHitAddr);
  assign missWr = cfgWe_i && (cfgAddr_i == refillBusPkg::CfgMissAddr);

  // flush lasts one cycle after the write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cacheEnable_o <= 1'b0;
      flushPulse_o <= 1'b0;
    end else begin
      flushPulse_o <= ctrlWr && cfgWdata_i[1];
      if (ctrlWr) begin
        cacheEnable_o <= cfgWdata_i[0];
      end
    end
  end

  // counters hold at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hitCnt <= '0;
      missCnt <= '0;
    end else begin
      if (hitWr) begin
        hitCnt <= '0;
      end else if (hitPulse_i && (hitCnt != '1)) begin
        hitCnt <= hitCnt + 1'b1;
      end
      if (missWr) begin
        missCnt <= '0;
      end else if (missPulse_i && (missCnt != '1)) begin
        missCnt <= missCnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfgAddr_i)
      refillBusPkg::CfgCtrlAddr: cfgRdata_o = {{(refillBusPkg::CfgDataW-1){1'b0}}, cacheEnable_o};
      refillBusPkg::CfgHitAddr:  cfgRdata_o = hitCnt;
      refillBusPkg::CfgMissAddr: cfgRdata_o = missCnt;
      default:                   cfgRdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/icacheTop.sv
`default_nettype none

module icacheTop (
  input  logic                  clk,
  input  logic                  rst_n,
  // pipeline
  input  logic                  valid_i,
  input  cacheGeomPkg::addrT     addr_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output cacheGeomPkg::wordT     rdData_o,
  // refill
  output logic                  memRdValid_o,
  output cacheGeomPkg::addrT     memAddr_o,
  input  logic                  memRdBeat_i,
  input  logic                  memRdLast_i,
  input  cacheGeomPkg::wordT     memRdData_i,
  // configuration
  input  logic                  cfgWe_i,
  input  refillBusPkg::cfgAddrT cfgAddr_i,
  input  refillBusPkg::cfgDataT cfgWdata_i,
  output refillBusPkg::cfgDataT cfgRdata_o
);

  logic hitWay0;
  logic hitWay1;
  logic victimWay;
  logic lookupEn;
  logic fillEn;
  logic touchEn;
  logic touchWay;
  logic dataEn;
  logic dataWe0;
  logic dataWe1;
  logic cacheEnable;
  logic flushPulse;
  logic hitPulse;
  logic missPulse;

  cacheGeomPkg::indexT lookupIndex;
  cacheGeomPkg::tagT   lookupTag;
  cacheGeomPkg::indexT dataIndex;
  cacheGeomPkg::lineT  fillLine;
  cacheGeomPkg::lineT  way0Line;
  cacheGeomPkg::lineT  way1Line;

  cacheCtrl i_cacheCtrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o),
    .memRdValid_o (memRdValid_o),
    .memAddr_o    (memAddr_o),
    .memRdBeat_i  (memRdBeat_i),
    .memRdLast_i  (memRdLast_i),
    .memRdData_i  (memRdData_i),
    .cacheEnable_i(cacheEnable),
    .hitWay0_i    (hitWay0),
    .hitWay1_i    (hitWay1),
    .victimWay_i  (victimWay),
    .lookupEn_o   (lookupEn),
    .lookupIndex_o(lookupIndex),
    .lookupTag_o  (lookupTag),
    .fillEn_o     (fillEn),
    .touchEn_o    (touchEn),
    .touchWay_o   (touchWay),
    .dataEn_o     (dataEn),
    .dataWe0_o    (dataWe0),
    .dataWe1_o    (dataWe1),
    .dataIndex_o  (dataIndex),
    .fillLine_o   (fillLine),
    .way0Line_i   (way0Line),
    .way1Line_i   (way1Line),
    .hitPulse_o   (hitPulse),
    .missPulse_o  (missPulse)
  );

  cacheTagStore i_cacheTagStore (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookupEn_i   (lookupEn),
    .lookupIndex_i(lookupIndex),
    .lookupTag_i  (lookupTag),
    .fillEn_i     (fillEn),
    .touchEn_i    (touchEn),
    .touchWay_i   (touchWay),
    .flush_i      (flushPulse),
    .hitWay0_o    (hitWay0),
    .hitWay1_o    (hitWay1),
    .victimWay_o  (victimWay)
  );

  // way 0
  cacheDataArray i_cacheDataArray0 (
    .clk     (clk),
    .en_i    (dataEn),
    .we_i    (dataWe0),
    .index_i (dataIndex),
    .wrLine_i(fillLine),
    .rdLine_o(way0Line)
  );

  // way 1
  cacheDataArray i_cacheDataArray1 (
    .clk     (clk),
    .en_i    (dataEn),
    .we_i    (dataWe1),
    .index_i (dataIndex),
    .wrLine_i(fillLine),
    .rdLine_o(way1Line)
  );

  cacheCfgRegs i_cacheCfgRegs (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfgWe_i      (cfgWe_i),
    .cfgAddr_i    (cfgAddr_i),
    .cfgWdata_i   (cfgWdata_i),
    .cfgRdata_o   (cfgRdata_o),
    .hitPulse_i   (hitPulse),
    .missPulse_i  (missPulse),
    .cacheEnable_o(cacheEnable),
    .flushPulse_o (flushPulse)
  );

endmodule

`default_nettype wire

// File: bench/refillMemModel.sv
`default_nettype none

module refillMemModel #(
  parameter cacheGeomPkg::addrT DataKey = 32'h0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               memRdValid_i,
  input  cacheGeomPkg::addrT memAddr_i,
  output logic               memRdBeat_o,
  output logic               memRdLast_o,
  output cacheGeomPkg::wordT memRdData_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int seed;
  logic busy;
  // set once the last beat went out, cleared when the request drops
  logic served;
  cacheGeomPkg::addrT lineAddr;
  refillBusPkg::beatCntT beatIdx;
  logic [1:0] gap;

  initial seed = 32'h7a0f_bb03;

  // 0 to 3 idle cycles before a beat
  function logic [1:0] drawGap();
    int r;
    r = $random(seed);
    return r[1:0];
  endfunction

  function cacheGeomPkg::wordT beatWord(cacheGeomPkg::addrT a);
    return {a ^ DataKey, a ^ DataKey};
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      served <= 1'b0;
      lineAddr <= '0;
      beatIdx <= '0;
      gap <= '0;
      memRdBeat_o <= 1'b0;
      memRdLast_o <= 1'b0;
      memRdData_o <= '0;
    end else begin
      memRdBeat_o <= 1'b0;
      memRdLast_o <= 1'b0;
      if (!memRdValid_i) begin
        served <= 1'b0;
      end
      if (!busy) begin
        if (memRdValid_i && !served) begin
          busy <= 1'b1;
          lineAddr <= memAddr_i;
          beatIdx <= '0;
          gap <= drawGap();
        end
      end else if (gap != 2'd0) begin
        gap <= gap - 1'b1;
      end else begin
        // beats go out in address order
        memRdBeat_o <= 1'b1;
        memRdData_o <= beatWord(lineAddr + (cacheGeomPkg::addrT'(beatIdx) << 3));
        if (beatIdx == refillBusPkg::beatCntT'(refillBusPkg::BeatsPerLine - 1)) begin
          memRdLast_o <= 1'b1;
          busy <= 1'b0;
          served <= 1'b1;
        end else begin
          beatIdx <= beatIdx + 1'b1;
          gap <= drawGap();
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/cacheTb.sv
`default_nettype none

module cacheTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam cacheGeomPkg::addrT DataKey = 32'h5a3c_96e1;

  typedef enum logic [1:0] {OpCfgWrite, OpCfgRead, OpRead, OpCountCheck} opT;

  typedef struct packed {
    opT                    op;
    refillBusPkg::cfgAddrT cfgAddr;
    logic [31:0]           value;
    logic [3:0]            count;
    logic [31:0]           expVal;
  } entryT;

  logic clk;
  logic rst_n;
  logic valid_i;
  cacheGeomPkg::addrT addr_i;
  logic addrOk_o;
  logic dataOk_o;
  cacheGeomPkg::wordT rdData_o;
  logic memRdValid_o;
  cacheGeomPkg::addrT memAddr_o;
  logic memRdBeat_i;
  logic memRdLast_i;
  cacheGeomPkg::wordT memRdData_i;
  logic cfgWe_i;
  refillBusPkg::cfgAddrT cfgAddr_i;
  refillBusPkg::cfgDataT cfgWdata_i;
  refillBusPkg::cfgDataT cfgRdata_o;

  entryT stimTable[$];
  logic tableReady;
  int errCount;
  int checkCount;
  int seed;

  // reference state of the cache
  logic refValid [cacheGeomPkg::NumSets][2];
  cacheGeomPkg::tagT refTag [cacheGeomPkg::NumSets][2];
  logic refLru [cacheGeomPkg::NumSets];
  logic refEnable;
  int refHits;
  int refMisses;

  always #10 clk = ~clk;

  icacheTop i_icacheTop (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .addr_i      (addr_i),
    .addrOk_o    (addrOk_o),
    .dataOk_o    (dataOk_o),
    .rdData_o    (rdData_o),
    .memRdValid_o(memRdValid_o),
    .memAddr_o   (memAddr_o),
    .memRdBeat_i (memRdBeat_i),
    .memRdLast_i (memRdLast_i),
    .memRdData_i (memRdData_i),
    .cfgWe_i     (cfgWe_i),
    .cfgAddr_i   (cfgAddr_i),
    .cfgWdata_i  (cfgWdata_i),
    .cfgRdata_o  (cfgRdata_o)
  );

  refillMemModel #(.DataKey(DataKey)) i_refillMemModel (
    .clk         (clk),
    .rst_n       (rst_n),
    .memRdValid_i(memRdValid_o),
    .memAddr_i   (memAddr_o),
    .memRdBeat_o (memRdBeat_i),
    .memRdLast_o (memRdLast_i),
    .memRdData_o (memRdData_i)
  );

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH at %0d ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  function automatic cacheGeomPkg::addrT makeAddr(int tag, int set, int word);
    return {cacheGeomPkg::tagT'(tag), cacheGeomPkg::indexT'(set),
            cacheGeomPkg::wordSelT'(word), 3'b000};
  endfunction

  // memory word is its aligned address xor the key in both halves
  function automatic cacheGeomPkg::wordT expectWord(cacheGeomPkg::addrT a);
    cacheGeomPkg::addrT w;
    w = a & ~32'h7;
    return {w ^ DataKey, w ^ DataKey};
  endfunction

  function automatic string opLabel(opT op);
    case (op)
      OpCfgWrite: return "cfg write";
      OpCfgRead:  return "cfg read";
      OpRead:     return "read";
      default:    return "counters";
    endcase
  endfunction

  task automatic addEntry(input opT op, input refillBusPkg::cfgAddrT ca, input logic [31:0] v,
                          input logic [3:0] n, input logic [31:0] e);
    entryT ent;
    ent.op = op;
    ent.cfgAddr = ca;
    ent.value = v;
    ent.count = n;
    ent.expVal = e;
    stimTable.push_back(ent);
  endtask

  task automatic modelFlush();
    for (int s = 0; s < cacheGeomPkg::NumSets; s++) begin
      refValid[s][0] = 1'b0;
      refValid[s][1] = 1'b0;
      refLru[s] = 1'b0;
    end
  endtask

  // one access in acceptance order
  // lru names the way replaced next
  task automatic modelAccess(input cacheGeomPkg::addrT a, output logic isHit);
    cacheGeomPkg::indexT set;
    cacheGeomPkg::tagT tag;
    logic way;
    set = a[cacheGeomPkg::OffsetW +: cacheGeomPkg::IndexW];
    tag = a[cacheGeomPkg::AddrW-1 -: cacheGeomPkg::TagW];
    isHit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (refEnable && refValid[set][w] && refTag[set][w] == tag) begin
        isHit = 1'b1;
        way = w[0];
      end
    end
    if (isHit) begin
      refHits++;
      refLru[set] = ~way;
    end else begin
      refMisses++;
      if (refEnable) begin
        way = refLru[set];
        refValid[set][way] = 1'b1;
        refTag[set][way] = tag;
        refLru[set] = ~way;
      end
    end
  endtask

  task automatic cfgWrite(input refillBusPkg::cfgAddrT a, input refillBusPkg::cfgDataT d);
    @(posedge clk);
    cfgWe_i <= 1'b1;
    cfgAddr_i <= a;
    cfgWdata_i <= d;
    @(posedge clk);
    cfgWe_i <= 1'b0;
    if (a == refillBusPkg::CfgCtrlAddr) begin
      refEnable = d[0];
      if (d[1]) begin
        modelFlush();
      end
    end else if (a == refillBusPkg::CfgHitAddr) begin
      refHits = 0;
    end else if (a == refillBusPkg::CfgMissAddr) begin
      refMisses = 0;
    end
  endtask

  task automatic cfgRead(input refillBusPkg::cfgAddrT a, output refillBusPkg::cfgDataT d);
    @(posedge clk);
    cfgAddr_i <= a;
    @(negedge clk);
    d = cfgRdata_o;
  endtask

  task automatic checkCounters();
    refillBusPkg::cfgDataT v;
    cfgRead(refillBusPkg::CfgHitAddr, v);
    checkValue("hit counter", 64'(v), 64'(refHits));
    cfgRead(refillBusPkg::CfgMissAddr, v);
    checkValue("miss counter", 64'(v), 64'(refMisses));
  endtask

  // streams count consecutive words from base with valid_i held high
  task automatic runReads(input cacheGeomPkg::addrT base, input int count);
    cacheGeomPkg::addrT pendAddr[$];
    int pendCyc[$];
    logic pendHit[$];
    cacheGeomPkg::addrT a;
    int issued;
    int done;
    int cyc;
    int acceptCyc;
    int lastOkCyc;
    logic lastHit;
    logic hitPred;
    logic accepted;
    logic isHit;
    issued = 0;
    done = 0;
    cyc = 0;
    lastOkCyc = 0;
    lastHit = 1'b0;
    @(posedge clk);
    valid_i <= 1'b1;
    addr_i <= base;
    while (done < count) begin
      @(negedge clk);
      cyc++;
      accepted = valid_i && addrOk_o;
      if (dataOk_o) begin
        if (pendAddr.size() == 0) begin
          errCount++;
          $display("dataOk_o pulsed at %0d ns with no request outstanding", $time);
          done = count;
        end else begin
          a = pendAddr.pop_front();
          acceptCyc = pendCyc.pop_front();
          hitPred = pendHit.pop_front();
          checkValue("rdData_o", rdData_o, expectWord(a));
          checkValue("dataOk_o one cycle after accept", 64'(cyc - acceptCyc == 1), 64'(hitPred));
          if (hitPred && lastHit) begin
            checkValue("dataOk_o back-to-back", 64'(cyc - lastOkCyc == 1), 64'd1);
          end
          lastHit = hitPred;
          lastOkCyc = cyc;
          done++;
        end
      end
      // a refill fetches the 32-byte line of the oldest pending read
      if (memRdValid_o && pendAddr.size() != 0) begin
        checkValue("memAddr_o", 64'(memAddr_o), 64'(pendAddr[0] & ~32'h1f));
      end
      if (accepted) begin
        modelAccess(addr_i, isHit);
        pendAddr.push_back(addr_i);
        pendCyc.push_back(cyc);
        pendHit.push_back(isHit);
        issued++;
      end
      @(posedge clk);
      if (accepted) begin
        if (issued < count) begin
          addr_i <= base + cacheGeomPkg::addrT'(issued * 8);
        end else begin
          valid_i <= 1'b0;
        end
      end
    end
  endtask

  task automatic buildTable();
    int rnd;
    int tagSel;
    // a disabled cache sends every access to memory
    addEntry(OpCountCheck, 2'd0, 32'd0, 4'd0, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(1, 3, 0), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(1, 3, 2), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(1, 3, 0), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(2, 9, 1), 4'd1, 32'd0);
    addEntry(OpCountCheck, 2'd0, 32'd0, 4'd0, 32'd0);
    addEntry(OpCfgRead, refillBusPkg::CfgCtrlAddr, 32'd0, 4'd0, 32'd0);
    // enable and clear counters before a miss and a burst of hits
    addEntry(OpCfgWrite, refillBusPkg::CfgCtrlAddr, 32'd1, 4'd0, 32'd0);
    addEntry(OpCfgRead, refillBusPkg::CfgCtrlAddr, 32'd0, 4'd0, 32'd1);
    addEntry(OpCfgWrite, refillBusPkg::CfgHitAddr, 32'd0, 4'd0, 32'd0);
    addEntry(OpCfgWrite, refillBusPkg::CfgMissAddr, 32'd0, 4'd0, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(5, 12, 1), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(5, 12, 0), 4'd4, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(5, 12, 3), 4'd1, 32'd0);
    addEntry(OpCountCheck, 2'd0, 32'd0, 4'd0, 32'd0);
    // tags A=7 B=8 C=9 share set 20 so C evicts B
    addEntry(OpRead, 2'd0, makeAddr(7, 20, 0), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(8, 20, 1), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(7, 20, 2), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(9, 20, 3), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(7, 20, 1), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(8, 20, 0), 4'd1, 32'd0);
    addEntry(OpCountCheck, 2'd0, 32'd0, 4'd0, 32'd0);
    // flush keeps enable set
    addEntry(OpCfgWrite, refillBusPkg::CfgCtrlAddr, 32'd3, 4'd0, 32'd0);
    addEntry(OpCfgRead, refillBusPkg::CfgCtrlAddr, 32'd0, 4'd0, 32'd1);
    addEntry(OpRead, 2'd0, makeAddr(5, 12, 2), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(5, 12, 2), 4'd1, 32'd0);
    addEntry(OpRead, 2'd0, makeAddr(7, 20, 0), 4'd1, 32'd0);
    addEntry(OpCountCheck, 2'd0, 32'd0, 4'd0, 32'd0);
    // counter clear by write
    addEntry(OpCfgWrite, refillBusPkg::CfgHitAddr, 32'hffff_ffff, 4'd0, 32'd0);
    addEntry(OpCfgRead, refillBusPkg::CfgHitAddr, 32'd0, 4'd0, 32'd0);
    addEntry(OpCountCheck, 2'd0, 32'd0, 4'd0, 32'd0);
    addEntry(OpCfgWrite, refillBusPkg::CfgMissAddr, 32'd5, 4'd0, 32'd0);
    addEntry(OpCfgRead, refillBusPkg::CfgMissAddr, 32'd0, 4'd0, 32'd0);
    // random words of three tags over sets 32 to 35
    for (int k = 0; k < 40; k++) begin
      rnd = $random(seed);
      tagSel = int'(rnd[5:2]) % 3;
      addEntry(OpRead, 2'd0, makeAddr(16'h100 + tagSel, 32 + int'(rnd[1:0]), int'(rnd[7:6])),
               4'd1, 32'd0);
    end
    addEntry(OpCountCheck, 2'd0, 32'd0, 4'd0, 32'd0);
    addEntry(OpCfgRead, refillBusPkg::CfgCtrlAddr, 32'd0, 4'd0, 32'd1);
  endtask

  initial begin
    tableReady = 1'b0;
    wait (tableReady);
    repeat (stimTable.size()) #200;
    $display("timeout: run did not end within 200 ns per table entry (%0d entries)",
             stimTable.size());
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    entryT ent;
    int errBefore;
    refillBusPkg::cfgDataT rdVal;
    clk = 1'b0;
    rst_n = 1'b0;
    valid_i = 1'b0;
    addr_i = '0;
    cfgWe_i = 1'b0;
    cfgAddr_i = '0;
    cfgWdata_i = '0;
    errCount = 0;
    checkCount = 0;
    seed = 32'h7a0f_bb03;
    refEnable = 1'b0;
    refHits = 0;
    refMisses = 0;
    modelFlush();
    buildTable();
    tableReady = 1'b1;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checkValue("addrOk_o after reset", 64'(addrOk_o), 64'd1);
    checkValue("dataOk_o after reset", 64'(dataOk_o), 64'd0);
    checkValue("memRdValid_o after reset", 64'(memRdValid_o), 64'd0);

    foreach (stimTable[i]) begin
      ent = stimTable[i];
      errBefore = errCount;
      case (ent.op)
        OpCfgWrite: cfgWrite(ent.cfgAddr, ent.value);
        OpCfgRead: begin
          cfgRead(ent.cfgAddr, rdVal);
          checkValue("cfgRdata_o", 64'(rdVal), 64'(ent.expVal));
        end
        OpRead: runReads(ent.value, int'(ent.count));
        default: checkCounters();
      endcase
      $display("test %0d %s 0x%08h: %s", i, opLabel(ent.op), ent.value,
               (errCount == errBefore) ? "ok" : "error");
    end

    $display("%0d tests, %0d checks, %0d errors", stimTable.size(), checkCount, errCount);
    if (errCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hw/cacheGeomPkg.sv
hw/refillBusPkg.sv
hw/cacheDataArray.sv
hw/cacheTagStore.sv
hw/cacheCtrl.sv
hw/cacheCfgRegs.sv
hw/icacheTop.sv
bench/refillMemModel.sv
bench/cacheTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
TOP       := cacheTb
FILELIST  := compile.f
OBJDIR    := obj_dir
SIMBIN    := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIMBIN)
	./$(SIMBIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
